// File: project.f
+incdir+verilog
verilog/bus_map_pkg.sv
verilog/timing_pkg.sv
verilog/cpu_reg_bank.sv
verilog/cpu_read_mux.sv
verilog/test_pattern_gen.sv
verilog/event_timer.sv
verilog/timer_bank.sv
verilog/monitor_top.sv
sim/tb_clock_gen.sv
sim/monitor_asserts.sv
sim/tb_monitor.sv

// File: sim/monitor_asserts.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module monitor_asserts (
  input logic                     clk_ext,
  input logic                     rst_ext,
  input logic [`ADDR_W-1:0]       bus_addr,
  input bus_map_pkg::bus_word_t   bus_rdata,
  input logic [7:0]               dip,
  input logic [3:0]               leds,
  input logic [7:0]               led2,
  input timing_pkg::timer_array_t timers
);

  int fail_count = 0;  // failed assertion tally

  task automatic flag_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  // ============================================================
  // bus side
  // ============================================================
  a_leds_reset: assert property (@(posedge clk_ext) rst_ext |=> leds == `LED_RESET)
    else flag_failure("leds left the reset pattern while reset was held");

  // indices past the timer window are unmapped
  a_dead_read: assert property (@(posedge clk_ext) disable iff (rst_ext)
    (bus_addr[`ADDR_W-1:2] > 14) |-> (bus_rdata == `DEAD_READ))
    else flag_failure("unmapped read index did not return the dead-read word");

  a_led2_dip: assert property (@(posedge clk_ext) led2[3:0] == dip[3:0])  // switches live
    else flag_failure("led2 low nibble does not follow dip");

  // ============================================================
  // timers, a value only clears or steps by one
  // ============================================================
  for (genvar t = 0; t < `NUM_TIMERS; t++) begin : g_timer_chk
    a_timer_step: assert property (@(posedge clk_ext) disable iff (rst_ext)
      $changed(timers[t]) |-> (timers[t] == '0) || (timers[t] == $past(timers[t]) + 1))
      else flag_failure("timer value changed without a start or a running count");
  end

endmodule

bind monitor_top monitor_asserts u_asserts (.*);

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_ext,
  output logic rst_ext
);

  initial begin
    clk_ext = 1'b0;
    forever #5 clk_ext = ~clk_ext;  // 10 ns period
  end

  // reset over the first three rising edges
  initial begin
    rst_ext = 1'b1;
    repeat (3) @(posedge clk_ext);
    rst_ext <= 1'b0;
  end

endmodule

// File: sim/tb_monitor.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module tb_monitor;

  localparam int MAX_CYCLES = 2000;  // sequence needs a few hundred cycles

  logic                    clk_ext;
  logic                    rst_ext;
  logic                    bus_cs;
  logic                    bus_rnw;
  logic [`ADDR_W-1:0]      bus_addr;
  bus_map_pkg::bus_word_t  bus_wdata;
  bus_map_pkg::bus_word_t  bus_rdata;
  logic [7:0]              dip;
  timing_pkg::stage_evt_t  stage_evt;
  logic [3:0]              leds;
  logic [7:0]              led2;
  logic                    led_test;
  int                      errors = 0;
  int                      tests = 0;
  int                      mark = 0;    // errors at test start
  int                      cycles = 0;
  int                      gap;
  logic [7:0]              dip_val;     // switch value being driven
  bus_map_pkg::bus_word_t  rd;
  bus_map_pkg::bus_word_t  held;

  tb_clock_gen u_clk_gen (.clk_ext(clk_ext), .rst_ext(rst_ext));

  monitor_top UUT (.*);

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // one bus cycle, read data taken mid-cycle
  task automatic bus_access(input logic rnw, input bus_map_pkg::reg_index_t idx,
                            input bus_map_pkg::bus_word_t data,
                            output bus_map_pkg::bus_word_t rdata);
    @(posedge clk_ext);
    bus_cs    <= 1'b1;
    bus_rnw   <= rnw;
    bus_addr  <= {idx, 2'b00};
    bus_wdata <= data;
    @(negedge clk_ext);
    rdata = bus_rdata;
    @(posedge clk_ext);  // write or read-access edge
    bus_cs    <= 1'b0;
    bus_rnw   <= 1'b1;
  endtask

  task automatic read_check(input bus_map_pkg::reg_index_t idx, input string name,
                            input bus_map_pkg::bus_word_t exp);
    bus_access(1'b1, idx, '0, rd);
    check_value(name, exp, rd);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s %s", tests, name, (errors == mark) ? "ok" : "with errors");
    mark = errors;
  endtask

  // ============================================================
  // cycle limit
  // ============================================================
  always @(posedge clk_ext) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, test sequence did not finish", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ============================================================
  // test sequence
  // ============================================================
  initial begin
    void'($urandom(96));
    bus_cs    = 1'b0;
    bus_rnw   = 1'b1;
    bus_addr  = '0;
    bus_wdata = '0;
    dip       = '0;
    stage_evt = '0;
    wait (rst_ext == 1'b0);

    read_check(bus_map_pkg::IDX_ID, "bus_rdata", `FIRMWARE_ID);
    read_check(bus_map_pkg::IDX_VERSION, "bus_rdata", {`FW_MAJOR, `FW_MINOR});
    repeat (3) begin
      @(posedge clk_ext);
      dip_val = 8'($urandom);
      dip <= dip_val;
      read_check(bus_map_pkg::IDX_DIP, "bus_rdata", {24'd0, dip_val});
    end
    read_check(14'd6, "bus_rdata", `DEAD_READ);  // hole between pattern and timers
    read_check(14'd15 + 14'($urandom % 200), "bus_rdata", `DEAD_READ);  // past the timers
    finish_test("register reads");

    held = $urandom;
    bus_access(1'b0, bus_map_pkg::IDX_LEDS, held, rd);
    bus_access(1'b0, bus_map_pkg::IDX_LED_TEST, 32'd1, rd);
    @(negedge clk_ext);
    check_value("leds", held[3:0], leds);
    check_value("led2", {held[3:0], dip[3:0]}, led2);
    check_value("led_test", 1'b1, led_test);
    finish_test("led writes");

    bus_access(1'b0, bus_map_pkg::IDX_TEST_FLAG, 32'd1, rd);  // flag pulse, ramp to init
    bus_access(1'b0, bus_map_pkg::IDX_TEST_FLAG, 32'd0, rd);
    for (int n = 1; n <= 5; n++) begin
      // n-th read sees init plus n-1
      read_check(bus_map_pkg::IDX_PATTERN, "pattern",
                 {16'(`PATTERN_Q_INIT + n - 1), 16'(`PATTERN_I_INIT + n - 1)});
    end
    finish_test("pattern ramp");

    gap = 4 + $urandom % 20;
    bus_access(1'b0, bus_map_pkg::IDX_T7_START, 32'd1, rd);
    repeat (gap - 2) @(posedge clk_ext);  // write edges gap apart
    bus_access(1'b0, bus_map_pkg::IDX_T7_STOP, 32'd1, rd);
    repeat (3) @(posedge clk_ext);
    read_check(14'd14, "timers[7]", gap - 1);
    repeat (1 + $urandom % 8) @(posedge clk_ext);
    read_check(14'd14, "timers[7]", gap - 1);  // still frozen
    finish_test("software timer");

    gap = 2 + $urandom % 15;
    bus_access(1'b0, bus_map_pkg::IDX_MODE_WORD, 32'h0000_8000, rd);  // mode field to run
    repeat (gap + 1) @(posedge clk_ext);  // strobe, then start edge
    stage_evt[3] <= 1'b1;
    @(posedge clk_ext);
    stage_evt[3] <= 1'b0;
    repeat (2) @(posedge clk_ext);
    read_check(14'd10, "timers[3]", gap - 1);
    // bit 0 is async, moves off the clock edge
    #3 stage_evt[0] <= 1'b1;
    #20 stage_evt[0] <= 1'b0;
    repeat (`SYNC_STAGES + 2) @(posedge clk_ext);
    bus_access(1'b1, 14'd7, '0, held);
    assert (held != 0) else begin
      $display("timer 0 read zero although it ran before its stop event");
      errors++;
    end
    repeat (4) @(posedge clk_ext);
    read_check(14'd7, "timers[0]", held);
    finish_test("latency timers");

    $display("%0d tests, %0d check errors, %0d assertion failures", tests, errors,
             UUT.u_asserts.fail_count);
    if ((errors == 0) && (UUT.u_asserts.fail_count == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/bus_map_pkg.sv
`include "monitor_defines.svh"

package bus_map_pkg;

  typedef logic [`DATA_W-1:0] bus_word_t;   // one bus data word
  typedef logic [13:0]        reg_index_t;  // word index, addr[15:2]

  // write side register map
  localparam reg_index_t IDX_LEDS      = 14'd1;
  localparam reg_index_t IDX_TEST_FLAG = 14'd2;
  localparam reg_index_t IDX_MODE_WORD = 14'd3;  // mode lives in [15:14]
  localparam reg_index_t IDX_LED_TEST  = 14'd4;
  localparam reg_index_t IDX_T6_STOP   = 14'd9;
  localparam reg_index_t IDX_T7_STOP   = 14'd10;
  localparam reg_index_t IDX_T7_START  = 14'd11;

  // read side register map
  localparam reg_index_t IDX_ID        = 14'd0;
  localparam reg_index_t IDX_VERSION   = 14'd1;
  localparam reg_index_t IDX_DIP       = 14'd2;
  localparam reg_index_t IDX_PATTERN   = 14'd5;
  localparam reg_index_t IDX_TIMER0    = 14'd7;  // timers sit at 7..14

  // byte address to word index
  function automatic reg_index_t word_index(input logic [`ADDR_W-1:0] addr);
    return addr[`ADDR_W-1:2];
  endfunction

endpackage

// File: verilog/cpu_read_mux.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module cpu_read_mux (
  input  logic [`ADDR_W-1:0]        bus_addr,
  input  logic [7:0]                dip,
  input  bus_map_pkg::bus_word_t    pattern,
  input  timing_pkg::timer_array_t  timers,
  output bus_map_pkg::bus_word_t    bus_rdata
);

  bus_map_pkg::reg_index_t rd_idx;
  timing_pkg::timer_idx_t  timer_sel;
  logic                    timer_hit;

  assign rd_idx    = bus_map_pkg::word_index(bus_addr);
  // timer window 7..14 folded onto timer number
  assign timer_hit = (rd_idx >= bus_map_pkg::IDX_TIMER0) &&
                     (rd_idx <  bus_map_pkg::IDX_TIMER0 + `NUM_TIMERS);
  assign timer_sel = timing_pkg::timer_idx_t'(rd_idx - bus_map_pkg::IDX_TIMER0);

  // ============================================================
  // read data select, same cycle, no handshake
  // ============================================================
  always_comb begin
    bus_rdata = `DEAD_READ;  // anything unmapped
    if (timer_hit) begin
      bus_rdata = timers[timer_sel];
    end else begin
      case (rd_idx)
        bus_map_pkg::IDX_ID:      bus_rdata = `FIRMWARE_ID;
        bus_map_pkg::IDX_VERSION: bus_rdata = {`FW_MAJOR, `FW_MINOR};  // major.minor
        bus_map_pkg::IDX_DIP:     bus_rdata = bus_map_pkg::bus_word_t'(dip);
        bus_map_pkg::IDX_PATTERN: bus_rdata = pattern;  // q high, i low
        default: begin
          bus_rdata = `DEAD_READ;
        end
      endcase
    end
  end

endmodule

// File: verilog/cpu_reg_bank.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module cpu_reg_bank (
  input  logic                     clk_ext,
  input  logic                     rst_ext,
  input  logic                     bus_cs,
  input  logic                     bus_rnw,
  input  logic [`ADDR_W-1:0]       bus_addr,
  input  bus_map_pkg::bus_word_t   bus_wdata,
  output logic [3:0]               leds,
  output logic                     test_flag,
  output timing_pkg::run_mode_t    mode,
  output logic                     led_test,
  output logic                     t6_stop_lvl,
  output logic                     t7_stop_lvl,
  output logic                     t7_start_lvl
);

  logic                    wr_en;
  bus_map_pkg::reg_index_t wr_idx;

  assign wr_en  = bus_cs & ~bus_rnw;  // no handshake, single cycle write
  assign wr_idx = bus_map_pkg::word_index(bus_addr);

  // ============================================================
  // software written registers
  // ============================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      leds         <= `LED_RESET;
      test_flag    <= 1'b0;
      mode         <= '0;
      led_test     <= 1'b0;
      t6_stop_lvl  <= 1'b0;
      t7_stop_lvl  <= 1'b0;
      t7_start_lvl <= 1'b0;
    end else if (wr_en) begin
      case (wr_idx)
        bus_map_pkg::IDX_LEDS: begin
          leds <= bus_wdata[3:0];
        end
        bus_map_pkg::IDX_TEST_FLAG: begin
          test_flag <= bus_wdata[0];  // held high resets the ramp
        end
        bus_map_pkg::IDX_MODE_WORD: begin
          mode <= bus_wdata[15:14];   // only the mode field is kept
        end
        bus_map_pkg::IDX_LED_TEST: begin
          led_test <= bus_wdata[0];
        end
        // timer flags, the bank edge-detects these levels
        bus_map_pkg::IDX_T6_STOP:  t6_stop_lvl  <= bus_wdata[0];
        bus_map_pkg::IDX_T7_STOP:  t7_stop_lvl  <= bus_wdata[0];
        bus_map_pkg::IDX_T7_START: t7_start_lvl <= bus_wdata[0];
        default: begin
          // unmapped write index, dropped
        end
      endcase
    end
  end

endmodule

// File: verilog/event_timer.sv
`timescale 1ns/1ps

module event_timer (
  input  logic                     clk_ext,
  input  logic                     rst_ext,
  input  logic                     start,
  input  logic                     stop,
  output timing_pkg::timer_value_t value
);

  logic running;

  // start clears and arms, stop freezes the count
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      value   <= '0;
      running <= 1'b0;
    end else if (start) begin  // start wins over stop
      value   <= '0;
      running <= 1'b1;
    end else if (stop) begin
      running <= 1'b0;         // count holds from here
    end else if (running) begin
      value   <= value + 1'b1;
    end
  end

endmodule

// File: verilog/monitor_defines.svh
`ifndef MONITOR_DEFINES_SVH
`define MONITOR_DEFINES_SVH

// ============================================================
// processor bus geometry
// ============================================================
`define DATA_W          32
`define ADDR_W          16

// identity and version words
`define FIRMWARE_ID     32'h55535250  // "USRP" in ascii
`define FW_MAJOR        16'h000A
`define FW_MINOR        16'h0001
`define DEAD_READ       32'hABADBABE  // unmapped read index

// reset values
`define LED_RESET       4'b1010
`define PATTERN_I_INIT  16'd0
`define PATTERN_Q_INIT  16'd32767     // q starts at mid-scale

// ============================================================
// latency timers
// ============================================================
`define NUM_TIMERS      8
`define SYNC_STAGES     3             // flops on async stage event 0

`endif

// File: verilog/monitor_top.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module monitor_top (
  input  logic                    clk_ext,
  input  logic                    rst_ext,
  input  logic                    bus_cs,
  input  logic                    bus_rnw,
  input  logic [`ADDR_W-1:0]      bus_addr,
  input  bus_map_pkg::bus_word_t  bus_wdata,
  output bus_map_pkg::bus_word_t  bus_rdata,
  input  logic [7:0]              dip,
  input  timing_pkg::stage_evt_t  stage_evt,
  output logic [3:0]              leds,
  output logic [7:0]              led2,
  output logic                    led_test
);

  logic                      test_flag;
  timing_pkg::run_mode_t     mode;
  logic                      t6_stop_lvl;
  logic                      t7_stop_lvl;
  logic                      t7_start_lvl;
  bus_map_pkg::bus_word_t    pattern;
  timing_pkg::timer_array_t  timers;

  // ============================================================
  // host register side
  // ============================================================
  cpu_reg_bank u_reg_bank (
    .clk_ext      (clk_ext),
    .rst_ext      (rst_ext),
    .bus_cs       (bus_cs),
    .bus_rnw      (bus_rnw),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .leds         (leds),
    .test_flag    (test_flag),
    .mode         (mode),
    .led_test     (led_test),
    .t6_stop_lvl  (t6_stop_lvl),
    .t7_stop_lvl  (t7_stop_lvl),
    .t7_start_lvl (t7_start_lvl)
  );

  cpu_read_mux u_read_mux (
    .bus_addr  (bus_addr),
    .dip       (dip),
    .pattern   (pattern),
    .timers    (timers),
    .bus_rdata (bus_rdata)
  );

  test_pattern_gen u_pattern (
    .clk_ext   (clk_ext),
    .rst_ext   (rst_ext),
    .bus_cs    (bus_cs),
    .bus_rnw   (bus_rnw),
    .test_flag (test_flag),
    .pattern   (pattern)
  );

  timer_bank u_timers (
    .clk_ext      (clk_ext),
    .rst_ext      (rst_ext),
    .mode         (mode),
    .t6_stop_lvl  (t6_stop_lvl),
    .t7_stop_lvl  (t7_stop_lvl),
    .t7_start_lvl (t7_start_lvl),
    .stage_evt    (stage_evt),
    .timers       (timers)
  );

  assign led2 = {leds, dip[3:0]};  // leds over switches

endmodule

// File: verilog/test_pattern_gen.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module test_pattern_gen (
  input  logic               clk_ext,
  input  logic               rst_ext,
  input  logic               bus_cs,
  input  logic               bus_rnw,
  input  logic               test_flag,
  output logic [`DATA_W-1:0] pattern
);

  logic [`DATA_W/2-1:0] pat_i;
  logic [`DATA_W/2-1:0] pat_q;

  // fake i/q ramp, one step per processor read
  always_ff @(posedge clk_ext) begin
    if (rst_ext || test_flag) begin  // test flag beats the increment
      pat_i <= `PATTERN_I_INIT;
      pat_q <= `PATTERN_Q_INIT;
    end else if (bus_cs && bus_rnw) begin
      pat_i <= pat_i + 1'b1;
      pat_q <= pat_q + 1'b1;        // wraps past full scale
    end
  end

  assign pattern = {pat_q, pat_i};

endmodule

// File: verilog/timer_bank.sv
`timescale 1ns/1ps
`include "monitor_defines.svh"

module timer_bank (
  input  logic                      clk_ext,
  input  logic                      rst_ext,
  input  timing_pkg::run_mode_t     mode,
  input  logic                      t6_stop_lvl,
  input  logic                      t7_stop_lvl,
  input  logic                      t7_start_lvl,
  input  timing_pkg::stage_evt_t    stage_evt,
  output timing_pkg::timer_array_t  timers
);

  timing_pkg::run_mode_t    mode_d;
  logic                     test_start;
  logic [2:0]               lvl;      // {t7 start, t7 stop, t6 stop}
  logic [2:0]               lvl_d;
  logic [2:0]               lvl_rise;
  logic [`SYNC_STAGES-1:0]  evt0_sync;
  logic [`NUM_TIMERS-1:0]   start_vec;
  logic [`NUM_TIMERS-1:0]   stop_vec;

  assign lvl = {t7_start_lvl, t7_stop_lvl, t6_stop_lvl};

  // ============================================================
  // strobes: test start, flag edges, async sync chain
  // ============================================================
  always_ff @(posedge clk_ext) begin
    if (rst_ext) begin
      mode_d     <= '0;
      test_start <= 1'b0;
      lvl_d      <= '0;
      lvl_rise   <= '0;
      evt0_sync  <= '0;
    end else begin
      mode_d     <= mode;
      // only on entry into run, not while sitting there
      test_start <= (mode == timing_pkg::MODE_RUN) && (mode_d != timing_pkg::MODE_RUN);
      lvl_d      <= lvl;
      lvl_rise   <= lvl & ~lvl_d;  // one cycle per 0->1 write
      evt0_sync  <= {evt0_sync[`SYNC_STAGES-2:0], stage_evt[0]};
    end
  end

  // timers 0..6 share test start, timer 7 is software started
  assign start_vec[`NUM_TIMERS-2:0] = {(`NUM_TIMERS-1){test_start}};
  assign start_vec[`NUM_TIMERS-1]   = lvl_rise[2];

  assign stop_vec[0]   = evt0_sync[`SYNC_STAGES-1];  // capture domain arrival
  assign stop_vec[5:1] = stage_evt[5:1];             // already in clk_ext domain
  assign stop_vec[6]   = lvl_rise[0];
  assign stop_vec[7]   = lvl_rise[1];

  for (genvar t = 0; t < `NUM_TIMERS; t++) begin : g_timer
    event_timer u_timer (
      .clk_ext (clk_ext),
      .rst_ext (rst_ext),
      .start   (start_vec[t]),
      .stop    (stop_vec[t]),
      .value   (timers[t])
    );
  end

endmodule

// File: verilog/timing_pkg.sv
`include "monitor_defines.svh"

package timing_pkg;

  typedef logic [31:0] timer_value_t;                   // cycle count
  typedef timer_value_t [`NUM_TIMERS-1:0] timer_array_t; // whole bank
  typedef logic [$clog2(`NUM_TIMERS)-1:0] timer_idx_t;   // picks one timer

  // software mode field
  typedef logic [1:0] run_mode_t;
  localparam run_mode_t MODE_RUN = 2'd2;  // entering this starts a test

  // bit 0 async, bits 1..5 are single-cycle pulses
  // 1 capture entry, 2 capture end, 3 fft start, 4 fft done, 5 thresh done
  typedef logic [5:0] stage_evt_t;

endpackage
